// ==== sim.f ====
rtl/opn_timing_pkg.sv
rtl/opn_prescaler.sv
rtl/opn_timer.sv
rtl/opn_regs.sv
rtl/opn_timing_top.sv
bench/opn_timing_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module opn_timing_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vopn_timing_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== bench/opn_timing_tb.sv ====
`timescale 1ns/1ps

module opn_timing_tb
    import opn_timing_pkg::*;
();

    localparam int wait_limit = 20000;  // clocks per wait loop

    logic        clk;
    logic        rst_n;
    logic        cen;
    logic        a0;
    logic [7:0]  din;
    logic        wr;
    logic [7:0]  dout;
    logic        irq_n;
    clk_ens_t    ens;

    clk_ens_t    ens_s;       // outputs as seen on the last falling edge
    logic        irq_n_s;
    logic [7:0]  dout_s;
    int          cen_total;   // cen cycles driven so far
    int          cen_at_s;    // cen_total behind the current sample
    int          fm_count;    // FM strobes taken by the timers
    int          errors;
    int          checks;
    int          tests;

    opn_timing_top dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .a0    (a0),
        .din   (din),
        .wr    (wr),
        .dout  (dout),
        .irq_n (irq_n),
        .ens   (ens)
    );

    always #20 clk = ~clk;

    // counted on the edge where the timers see the strobe
    always @(posedge clk) begin
        if (ens.fm) begin
            fm_count = fm_count + 1;
        end
    end

    // one clock: sample outputs, then drive the next inputs
    task automatic tick(input logic c);
        @(negedge clk);
        ens_s    = ens;
        irq_n_s  = irq_n;
        dout_s   = dout;
        cen_at_s = cen_total;  // includes the cen that made this sample
        wr       = 1'b0;
        a0       = 1'b0;
        cen      = c;
        if (c) begin
            cen_total++;
        end
    endtask

    // address then data; wr drops on the next tick
    task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data);
        @(negedge clk);
        cen = 1'b0;  // no strobes in flight around the write
        wr  = 1'b1;
        a0  = 1'b0;
        din = addr;
        @(negedge clk);
        a0  = 1'b1;
        din = data;
    endtask

    task automatic check_eq(input string test, input string what, input int exp, input int got);
        checks++;
        assert (got == exp) else begin
            $display("error %s: %s expected %0d, got %0d", test, what, exp, got);
            errors++;
        end
    endtask

    task automatic timed_out(input string test, input string what);
        errors++;
        $display("%s: timed out, %s never came", test, what);
    endtask

    task automatic report_test(input string test, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", test);
        end else begin
            $display("test %s: %0d errors", test, errors - errs_before);
        end
    endtask

    function automatic logic rand_cen();
        return ($urandom % 3) != 0;  // roughly two in three
    endfunction

    function automatic logic strobe_of(input clk_ens_t e, input int sel);
        case (sel)
            0:       return e.fm;
            1:       return e.ssg;
            2:       return e.adpcm;
            default: return e.adpcm3;
        endcase
    endfunction

    // cen cycles between two strobes in a row
    task automatic measure_spacing(input string test, input string what, input int sel,
                                   input bit gaps, input int exp);
        int marks[$];
        int n;
        n = 0;
        while (marks.size() < 2 && n < wait_limit) begin
            tick(gaps ? rand_cen() : 1'b1);
            n++;
            if (strobe_of(ens_s, sel)) begin
                marks.push_back(cen_at_s);
            end
        end
        if (marks.size() < 2) begin
            timed_out(test, {"a second ", what, " strobe"});
        end else begin
            check_eq(test, {what, " spacing"}, exp, marks[1] - marks[0]);
        end
    endtask

    task automatic wait_irq(input string test, input logic level, output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < wait_limit) begin
            tick(1'b1);
            n++;
            seen = (irq_n_s == level);
        end
        if (!seen) begin
            timed_out(test, level ? "the rise of irq_n" : "the fall of irq_n");
        end
    endtask

    // irq_n and status must stay quiet for this many FM strobes
    task automatic quiet_run(input string test, input int strobes);
        int base;
        int n;
        int irq_cycles;
        int flag_cycles;
        base = fm_count;
        n = 0;
        irq_cycles = 0;
        flag_cycles = 0;
        while (fm_count - base < strobes && n < wait_limit) begin
            tick(1'b1);
            n++;
            if (!irq_n_s) irq_cycles++;
            if (dout_s[1:0] != 2'b00) flag_cycles++;
        end
        if (fm_count - base < strobes) begin
            timed_out(test, "the last FM strobe of the quiet run");
        end
        check_eq(test, "cycles with irq_n low", 0, irq_cycles);
        check_eq(test, "cycles with a status flag", 0, flag_cycles);
    endtask

    task automatic after_reset_idle();
        int e0;
        e0 = errors;
        repeat (20) begin
            tick(1'b0);
            check_eq("after_reset", "strobes", 0, int'(ens_s));
            check_eq("after_reset", "irq_n", 1, int'(irq_n_s));
            check_eq("after_reset", "dout", 0, int'(dout_s));
        end
        report_test("after_reset", e0);
    endtask

    // reset ratio: FM /6, SSG /4, ADPCM /4, ADPCM/3 /24
    task automatic default_ratios();
        int e0;
        e0 = errors;
        measure_spacing("default_ratios", "fm", 0, 1'b0, 6);
        measure_spacing("default_ratios", "ssg", 1, 1'b0, 4);
        measure_spacing("default_ratios", "adpcm", 2, 1'b0, 4);
        measure_spacing("default_ratios", "adpcm3", 3, 1'b0, 24);
        report_test("default_ratios", e0);
    endtask

    task automatic switch_prescaler(input logic [7:0] addr, input int fm_exp, input int ssg_exp);
        cpu_write(addr, 8'($urandom));  // data byte is ignored
        tick(1'b0);
        tick(1'b0);                     // counters cleared by now
        tick(1'b1);
        tick(1'b0);
        check_eq("prescaler_cmds", "strobes after restart", 'hF, int'(ens_s));
        measure_spacing("prescaler_cmds", "fm", 0, 1'b1, fm_exp);
        measure_spacing("prescaler_cmds", "ssg", 1, 1'b1, ssg_exp);
    endtask

    task automatic prescaler_commands();
        int e0;
        e0 = errors;
        switch_prescaler(addr_prescale_3, 3, 2);
        switch_prescaler(addr_prescale_2, 2, 1);
        switch_prescaler(addr_prescale_6, 6, 4);  // back to reset ratio
        report_test("prescaler_cmds", e0);
    endtask

    task automatic timer_a_overflow();
        int e0;
        int v;
        int base;
        bit seen;
        e0 = errors;
        v = 1024 - 20 - int'($urandom % 40);  // short period
        cpu_write(addr_timer_a_hi, 8'(v >> 2));
        cpu_write(addr_timer_a_lo, 8'(v & 3));
        cpu_write(addr_timer_ctrl, 8'h05);    // load_a, irq_en_a
        base = fm_count;
        wait_irq("timer_a", 1'b0, seen);
        if (seen) begin
            check_eq("timer_a", "fm strobes to overflow", 1024 - v, fm_count - base);
            check_eq("timer_a", "status bit 0", 1, int'(dout_s[0]));
            base = fm_count;                   // reload happened on that strobe
            cpu_write(addr_timer_ctrl, 8'h15); // clear_a, keeps running
            wait_irq("timer_a", 1'b1, seen);
            if (seen) begin
                wait_irq("timer_a", 1'b0, seen);
                if (seen) begin
                    check_eq("timer_a", "fm strobes after reload", 1024 - v, fm_count - base);
                end
            end
        end
        cpu_write(addr_timer_ctrl, 8'h10);    // stop and clear
        tick(1'b1);
        tick(1'b1);
        report_test("timer_a", e0);
    endtask

    task automatic timer_b_overflow();
        int e0;
        int v;
        int base;
        bit seen;
        e0 = errors;
        v = 256 - 2 - int'($urandom % 3);
        cpu_write(addr_timer_b, 8'(v));
        cpu_write(addr_timer_ctrl, 8'h0A);    // load_b, irq_en_b
        base = fm_count;
        wait_irq("timer_b", 1'b0, seen);      // flag_a is clear, so this is flag_b
        if (seen) begin
            check_eq("timer_b", "fm strobes to overflow", 16 * (256 - v),
                     fm_count - base);
            check_eq("timer_b", "status bits", 2, int'(dout_s[1:0]));
            cpu_write(addr_timer_ctrl, 8'h22); // clear_b, irq_en_b off
            wait_irq("timer_b", 1'b1, seen);
            if (seen) begin
                quiet_run("timer_b", 2 * 16 * (256 - v) + 16);
            end
        end
        cpu_write(addr_timer_ctrl, 8'h20);
        tick(1'b1);
        report_test("timer_b", e0);
    endtask

    task automatic timer_stop();
        int e0;
        int v;
        e0 = errors;
        v = 1024 - 20 - int'($urandom % 40);
        cpu_write(addr_timer_a_hi, 8'(v >> 2));
        cpu_write(addr_timer_a_lo, 8'(v & 3));
        cpu_write(addr_timer_ctrl, 8'h05);
        repeat (30) tick(1'b1);               // a few strobes, well short of overflow
        cpu_write(addr_timer_ctrl, 8'h04);    // load_a off, irq still enabled
        quiet_run("timer_stop", 2 * (1024 - v));
        cpu_write(addr_timer_ctrl, 8'h00);
        tick(1'b1);
        report_test("timer_stop", e0);
    endtask

    initial begin
        void'($urandom(32'h8d92_5e5a));
        clk       = 1'b0;
        rst_n     = 1'b0;
        cen       = 1'b0;
        a0        = 1'b0;
        din       = 8'h00;
        wr        = 1'b0;
        ens_s     = '0;
        irq_n_s   = 1'b1;
        dout_s    = 8'h00;
        cen_total = 0;
        cen_at_s  = 0;
        fm_count  = 0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        after_reset_idle();
        default_ratios();
        prescaler_commands();
        timer_a_overflow();
        timer_b_overflow();
        timer_stop();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== rtl/opn_timing_top.sv ====
`timescale 1ns/1ps

module opn_timing_top
    import opn_timing_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  logic       a0,
    input  logic [7:0] din,
    input  logic       wr,
    output logic [7:0] dout,
    output logic       irq_n,
    output clk_ens_t   ens
);

    prescale_t            setting;
    logic                 presc_restart;
    logic [timer_a_w-1:0] value_a;
    logic [timer_b_w-1:0] value_b;
    timer_ctrl_t          ctrl;
    logic                 clear_a;
    logic                 clear_b;
    logic                 flag_a;
    logic                 flag_b;

    opn_regs regs_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .a0            (a0),
        .din           (din),
        .wr            (wr),
        .flag_a        (flag_a),
        .flag_b        (flag_b),
        .dout          (dout),
        .setting       (setting),
        .presc_restart (presc_restart),
        .value_a       (value_a),
        .value_b       (value_b),
        .ctrl          (ctrl),
        .clear_a       (clear_a),
        .clear_b       (clear_b)
    );

    opn_prescaler prescaler_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .setting (setting),
        .restart (presc_restart),
        .ens     (ens)
    );

    // timer A steps on every FM strobe
    opn_timer #(.cnt_w(timer_a_w), .sub_div(1)) timer_a (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick   (ens.fm),
        .value  (value_a),
        .load   (ctrl.load_a),
        .irq_en (ctrl.irq_en_a),
        .clear  (clear_a),
        .flag   (flag_a)
    );

    // timer B, 16 FM strobes per step
    opn_timer #(.cnt_w(timer_b_w), .sub_div(timer_b_sub)) timer_b (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick   (ens.fm),
        .value  (value_b),
        .load   (ctrl.load_b),
        .irq_en (ctrl.irq_en_b),
        .clear  (clear_b),
        .flag   (flag_b)
    );

    assign irq_n = ~(flag_a | flag_b);  // low while either flag is up

endmodule

// ==== rtl/opn_regs.sv ====
`timescale 1ns/1ps

module opn_regs
    import opn_timing_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        a0,
    input  logic [7:0]  din,
    input  logic        wr,
    input  logic        flag_a,
    input  logic        flag_b,
    output logic [7:0]  dout,
    output prescale_t   setting,
    output logic        presc_restart,
    output logic [9:0]  value_a,
    output logic [7:0]  value_b,
    output timer_ctrl_t ctrl,
    output logic        clear_a,
    output logic        clear_b
);

    logic [7:0] addr;      // latched by a0=0 writes
    logic [7:0] ta_hi;
    logic [1:0] ta_lo;
    logic [7:0] tb;
    logic       wr_addr;
    logic       wr_data;
    logic       hit_presc;
    logic       hit_ctrl;

    assign wr_addr = wr & ~a0;
    assign wr_data = wr & a0;

    // any of the three prescaler commands
    assign hit_presc = (addr == addr_prescale_6) |
                       (addr == addr_prescale_3) |
                       (addr == addr_prescale_2);
    assign hit_ctrl  = (addr == addr_timer_ctrl);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (wr_addr) begin
            addr <= din;
        end
    end

    // timer A and B start values
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ta_hi <= '0;
            ta_lo <= '0;
            tb    <= '0;
        end else if (wr_data) begin
            case (addr)
                addr_timer_a_hi: ta_hi <= din;
                addr_timer_a_lo: ta_lo <= din[1:0];  // upper bits dropped
                addr_timer_b:    tb    <= din;
                default: ;
            endcase
        end
    end

    // prescaler setting, data byte is don't care
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            setting <= prescale_reset;
        end else if (wr_data) begin
            case (addr)
                addr_prescale_6: setting <= 2'b10;
                addr_prescale_3: setting <= 2'b11;
                addr_prescale_2: setting <= 2'b00;
                default: ;
            endcase
        end
    end

    // 0x27 held as written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else if (wr_data && hit_ctrl) begin
            ctrl <= timer_ctrl_t'(din[5:0]);
        end
    end

    // one-cycle pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc_restart <= 1'b0;
            clear_a       <= 1'b0;
            clear_b       <= 1'b0;
        end else begin
            presc_restart <= wr_data & hit_presc;
            clear_a       <= wr_data & hit_ctrl & din[4];
            clear_b       <= wr_data & hit_ctrl & din[5];
        end
    end

    assign value_a = {ta_hi, ta_lo};  // 0x24 is the high part
    assign value_b = tb;

    // status byte, overflow flags only
    assign dout = {6'd0, flag_b, flag_a};

endmodule

// ==== rtl/opn_timer.sv ====
`timescale 1ns/1ps

module opn_timer
    import opn_timing_pkg::*;
#(
    parameter int unsigned cnt_w   = timer_a_w,
    parameter int unsigned sub_div = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,
    input  logic [cnt_w-1:0] value,
    input  logic             load,
    input  logic             irq_en,
    input  logic             clear,
    output logic             flag
);

    // at least one bit even when there is no sub-prescaler
    localparam int unsigned sub_w = (sub_div > 1) ? $clog2(sub_div) : 1;

    logic [cnt_w-1:0] cnt;
    logic [sub_w-1:0] sub_cnt;
    logic             load_q;
    logic             load_rise;
    logic             sub_last;
    logic             step;
    logic             ovf;

    assign load_rise = load & ~load_q;  // start only, no reload while running
    assign sub_last  = (sub_cnt == sub_w'(sub_div - 1));
    assign step      = load & ~load_rise & tick & sub_last;
    assign ovf       = step & (&cnt);   // step taken at all ones

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
        end else begin
            load_q <= load;
        end
    end

    // tick prescale, restarts together with the counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sub_cnt <= '0;
        end else if (!load || load_rise) begin
            sub_cnt <= '0;
        end else if (tick) begin
            sub_cnt <= sub_last ? '0 : sub_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load_rise) begin
            cnt <= value;
        end else if (step) begin
            cnt <= ovf ? value : cnt + 1'b1;  // reload on wrap
        end
    end

    // sticky, a set wins over a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag <= 1'b0;
        end else begin
            flag <= (flag & ~clear) | (ovf & irq_en);
        end
    end

endmodule

// ==== rtl/opn_prescaler.sv ====
`timescale 1ns/1ps

module opn_prescaler
    import opn_timing_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cen,
    input  prescale_t setting,
    input  logic      restart,
    output clk_ens_t  ens
);

    logic [3:0] fm_cnt;
    logic [2:0] ssg_cnt;
    logic [2:0] adpcm_cnt;
    logic [2:0] adpcm3_cnt;
    logic [3:0] fm_last;      // wrap point, ratio minus one
    logic [2:0] ssg_last;
    prescale_t  setting_q;    // previous setting, for change detect
    logic       clr;
    logic       fm_zero;
    logic       ssg_zero;
    logic       adpcm_zero;
    logic       adpcm3_zero;

    assign fm_last  = fm_div_of(setting) - 4'd1;
    assign ssg_last = ssg_div_of(setting) - 3'd1;

    // restart on command or on any ratio change
    assign clr = restart | (setting != setting_q);

    assign fm_zero     = (fm_cnt == 4'd0);
    assign ssg_zero    = (ssg_cnt == 3'd0);
    assign adpcm_zero  = (adpcm_cnt == 3'd0);
    assign adpcm3_zero = (adpcm3_cnt == 3'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            setting_q <= prescale_reset;
        end else begin
            setting_q <= setting;
        end
    end

    // all four counters only move on cen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm_cnt     <= '0;
            ssg_cnt    <= '0;
            adpcm_cnt  <= '0;
            adpcm3_cnt <= '0;
        end else if (clr) begin
            fm_cnt     <= '0;  // next cen fires everything
            ssg_cnt    <= '0;
            adpcm_cnt  <= '0;
            adpcm3_cnt <= '0;
        end else if (cen) begin
            fm_cnt  <= (fm_cnt >= fm_last) ? 4'd0 : fm_cnt + 4'd1;
            ssg_cnt <= (ssg_cnt >= ssg_last) ? 3'd0 : ssg_cnt + 3'd1;
            adpcm_cnt <= (adpcm_cnt == 3'(adpcm_div - 1)) ? 3'd0 : adpcm_cnt + 3'd1;
            if (adpcm_zero) begin
                // slow rate, one step per ADPCM strobe
                adpcm3_cnt <= (adpcm3_cnt == 3'(adpcm3_div - 1)) ? 3'd0
                                                                 : adpcm3_cnt + 3'd1;
            end
        end
    end

    // zero detect registered, so strobes come out of a flop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ens <= '0;
        end else begin
            ens.fm     <= cen & ~clr & fm_zero;
            ens.ssg    <= cen & ~clr & ssg_zero;
            ens.adpcm  <= cen & ~clr & adpcm_zero;
            ens.adpcm3 <= cen & ~clr & adpcm_zero & adpcm3_zero;  // 1 in 24
        end
    end

endmodule

// ==== rtl/opn_timing_pkg.sv ====
package opn_timing_pkg;

    // register map, addresses as latched by an a0=0 write
    localparam logic [7:0] addr_timer_a_hi = 8'h24;  // timer A bits 9..2
    localparam logic [7:0] addr_timer_a_lo = 8'h25;  // timer A bits 1..0
    localparam logic [7:0] addr_timer_b    = 8'h26;
    localparam logic [7:0] addr_timer_ctrl = 8'h27;
    localparam logic [7:0] addr_prescale_6 = 8'h2D;  // FM /6, SSG /4
    localparam logic [7:0] addr_prescale_3 = 8'h2E;  // FM /3, SSG /2
    localparam logic [7:0] addr_prescale_2 = 8'h2F;  // FM /2, SSG /1

    // fixed dividers
    localparam int unsigned adpcm_div   = 4;   // cen per ADPCM strobe
    localparam int unsigned adpcm3_div  = 6;   // ADPCM per ADPCM/3 strobe
    localparam int unsigned timer_b_sub = 16;  // FM strobes per timer B step

    // timer widths
    localparam int unsigned timer_a_w = 10;
    localparam int unsigned timer_b_w = 8;

    // 2'b10 after reset, 2'b0x means the fastest rate
    typedef logic [1:0] prescale_t;

    localparam prescale_t prescale_reset = 2'b10;

    typedef struct packed {
        logic fm;
        logic ssg;
        logic adpcm;
        logic adpcm3;
    } clk_ens_t;

    // laid out MSB first so bit 0 of 0x27 lands on load_a
    typedef struct packed {
        logic clear_b;   // bit 5
        logic clear_a;   // bit 4
        logic irq_en_b;  // bit 3
        logic irq_en_a;  // bit 2
        logic load_b;    // bit 1
        logic load_a;    // bit 0
    } timer_ctrl_t;

    // cen cycles per FM strobe
    function automatic logic [3:0] fm_div_of(input prescale_t s);
        case (s)
            2'b10:   return 4'd6;
            2'b11:   return 4'd3;
            default: return 4'd2;  // 2'b0x
        endcase
    endfunction

    // cen cycles per SSG strobe
    function automatic logic [2:0] ssg_div_of(input prescale_t s);
        case (s)
            2'b10:   return 3'd4;
            2'b11:   return 3'd2;
            default: return 3'd1;
        endcase
    endfunction

endpackage
